/* filelist.f */
design/isa_pkg.sv
design/backend_pkg.sv
design/decode_stage.sv
design/execute_stage.sv
design/result_stage.sv
design/mini_backend.sv
sim/tb_clock_gen.sv
sim/tb_mini_backend.sv

/* Bender.yml */
package:
  name: mini_backend

sources:
  - design/isa_pkg.sv
  - design/backend_pkg.sv
  - design/decode_stage.sv
  - design/execute_stage.sv
  - design/result_stage.sv
  - design/mini_backend.sv
  - target: test
    files:
      - sim/tb_clock_gen.sv
      - sim/tb_mini_backend.sv

/* sim/tb_mini_backend.sv */
`timescale 1ns/1ns

module tb_mini_backend;

    localparam int XLEN      = 32;
    localparam int NUM_ROWS  = 16;
    localparam int DRIVE_DLY = 2;
    localparam int WAIT_MAX  = 20;
    localparam int RAND_SEED = 31;

    typedef struct packed {
        isa_pkg::inst_u [1:0]  inst;
        logic [1:0]            vld;
        backend_pkg::ftq_idx_t ftq;
        logic                  exp_stall;
    } row_t;

    typedef struct packed {
        int                          row;
        backend_pkg::ftq_idx_t       ftq;
        logic [1:0]                  wb_vld;
        backend_pkg::reg_idx_t [1:0] wb_rd;
        logic [1:0][XLEN-1:0]        wb_data;
        logic                        br_vld;
        logic                        br_taken;
        logic [XLEN-1:0]             br_target;
    } expect_t;

    logic                  clk;
    logic                  rst_n;
    logic                  inst_vld [backend_pkg::FETCH_WIDTH];
    isa_pkg::inst_u        inst [backend_pkg::FETCH_WIDTH];
    backend_pkg::ftq_idx_t ftq_idx;
    logic                  stall;
    backend_pkg::ftq_idx_t read_ftq_idx;
    logic [XLEN-1:0]       read_start_addr;
    logic                  wb_vld [backend_pkg::FETCH_WIDTH];
    backend_pkg::reg_idx_t wb_rd [backend_pkg::FETCH_WIDTH];
    logic [XLEN-1:0]       wb_data [backend_pkg::FETCH_WIDTH];
    logic                  br_vld;
    backend_pkg::ftq_idx_t br_ftq_idx;
    logic                  br_taken;
    logic [XLEN-1:0]       br_target;
    logic                  squash_vld;
    logic [XLEN-1:0]       squash_pc;
    logic                  commit_vld;
    backend_pkg::ftq_idx_t commit_ftq_idx;

    logic [XLEN-1:0] ftq_start [16];
    logic [XLEN-1:0] model_rf [backend_pkg::NUM_REGS];
    row_t            table_rows [NUM_ROWS];
    bit              row_bad [NUM_ROWS];
    expect_t         exp_q [$];
    int              err_cnt = 0;
    int              rows_ok = 0;
    int              rows_bad = 0;
    bit              timed_out = 1'b0;

    tb_clock_gen #(.PERIOD(40), .RST_CYCLES(2)) u_clk_gen (
        .o_clk  ( clk   ),
        .o_rst_n( rst_n )
    );

    mini_backend #(.XLEN(XLEN)) uut (
        .i_clk                ( clk             ),
        .i_rst_n              ( rst_n           ),
        .i_inst_vld           ( inst_vld        ),
        .i_inst               ( inst            ),
        .i_ftq_idx            ( ftq_idx         ),
        .o_stall              ( stall           ),
        .o_read_ftq_idx       ( read_ftq_idx    ),
        .i_read_ftq_start_addr( read_start_addr ),
        .o_wb_vld             ( wb_vld          ),
        .o_wb_rd              ( wb_rd           ),
        .o_wb_data            ( wb_data         ),
        .o_branchwb_vld       ( br_vld          ),
        .o_branchwb_ftq_idx   ( br_ftq_idx      ),
        .o_branchwb_taken     ( br_taken        ),
        .o_branchwb_target    ( br_target       ),
        .o_squash_vld         ( squash_vld      ),
        .o_squash_pc          ( squash_pc       ),
        .o_commit_vld         ( commit_vld      ),
        .o_commit_ftq_idx     ( commit_ftq_idx  )
    );

    // fetch queue start address lookup
    assign read_start_addr = ftq_start[read_ftq_idx];

    function automatic isa_pkg::inst_u enc_reg(isa_pkg::opcode_e op, int rd, int rs1, int rs2);
        isa_pkg::inst_u w;
        w          = '0;
        w.r.opcode = op;
        w.r.rd     = 3'(rd);
        w.r.rs1    = 3'(rs1);
        w.r.rs2    = 3'(rs2);
        return w;
    endfunction

    function automatic isa_pkg::inst_u enc_imm(isa_pkg::opcode_e op, int rd, int rs1, int rs2,
                                               int imm);
        isa_pkg::inst_u w;
        w          = '0;
        w.i.opcode = op;
        w.i.rd     = 3'(rd);
        w.i.rs1    = 3'(rs1);
        w.i.rs2    = 3'(rs2);
        w.i.imm    = 16'(imm);
        return w;
    endfunction

    // vld bit 0 is lane 0
    function automatic row_t make_row(isa_pkg::inst_u w0, isa_pkg::inst_u w1, logic [1:0] vld,
                                      int ftq, logic exp_stall);
        row_t r;
        r.inst[0]   = w0;
        r.inst[1]   = w1;
        r.vld       = vld;
        r.ftq       = backend_pkg::ftq_idx_t'(ftq);
        r.exp_stall = exp_stall;
        return r;
    endfunction

    task automatic fill_table();
        isa_pkg::inst_u nop;
        nop = enc_reg(isa_pkg::OP_NOP, 0, 0, 0);
        // single lane alu ops, r7 still reads zero from reset
        table_rows[0]  = make_row(enc_imm(isa_pkg::OP_ADDI, 1, 0, 0, 5), nop, 2'b01, 0, 1'b0);
        table_rows[1]  = make_row(enc_imm(isa_pkg::OP_ADDI, 2, 7, 0, -3), nop, 2'b01, 1, 1'b0);
        table_rows[2]  = make_row(enc_reg(isa_pkg::OP_ADD, 3, 1, 2), nop, 2'b01, 2, 1'b0);
        table_rows[3]  = make_row(enc_reg(isa_pkg::OP_SUB, 4, 1, 2), nop, 2'b01, 3, 1'b0);
        // lane 1 reads lane 0's destination
        table_rows[4]  = make_row(enc_imm(isa_pkg::OP_ADDI, 5, 1, 0, 10),
                                  enc_reg(isa_pkg::OP_ADD, 6, 5, 1), 2'b11, 4, 1'b0);
        table_rows[5]  = make_row(enc_reg(isa_pkg::OP_SUB, 7, 5, 3),
                                  enc_imm(isa_pkg::OP_ADDI, 1, 7, 0, 1), 2'b11, 5, 1'b0);
        // taken beq in lane 0 kills lane 1 and the next bundle
        table_rows[6]  = make_row(enc_imm(isa_pkg::OP_BEQ, 0, 0, 0, 3),
                                  enc_imm(isa_pkg::OP_ADDI, 2, 0, 0, 100), 2'b11, 6, 1'b0);
        table_rows[7]  = make_row(enc_imm(isa_pkg::OP_ADDI, 3, 0, 0, 77), nop, 2'b01, 7, 1'b1);
        // two branches, lane 0 not taken
        table_rows[8]  = make_row(enc_imm(isa_pkg::OP_BNE, 0, 1, 1, 5),
                                  enc_imm(isa_pkg::OP_BEQ, 0, 0, 0, 2), 2'b11, 8, 1'b0);
        table_rows[9]  = make_row(enc_imm(isa_pkg::OP_BNE, 0, 1, 2, -2),
                                  enc_imm(isa_pkg::OP_BEQ, 0, 0, 0, 4), 2'b11, 9, 1'b0);
        table_rows[10] = make_row(enc_reg(isa_pkg::OP_ADD, 4, 1, 1), nop, 2'b01, 10, 1'b1);
        // taken branch in lane 1 on a bypassed operand
        table_rows[11] = make_row(enc_imm(isa_pkg::OP_ADDI, 3, 6, 0, 1),
                                  enc_imm(isa_pkg::OP_BNE, 0, 3, 0, 1), 2'b11, 11, 1'b0);
        table_rows[12] = make_row(enc_imm(isa_pkg::OP_ADDI, 5, 0, 0, 1), nop, 2'b01, 12, 1'b1);
        // back to back, three bundles in flight
        table_rows[13] = make_row(enc_reg(isa_pkg::OP_ADD, 4, 3, 3),
                                  enc_reg(isa_pkg::OP_SUB, 5, 4, 1), 2'b11, 13, 1'b0);
        table_rows[14] = make_row(enc_imm(isa_pkg::OP_ADDI, 6, 5, 0, -100),
                                  enc_imm(isa_pkg::OP_ADDI, 7, 7, 0, 2), 2'b11, 14, 1'b0);
        table_rows[15] = make_row(enc_reg(isa_pkg::OP_ADD, 2, 4, 6),
                                  enc_imm(isa_pkg::OP_ADDI, 1, 0, 0, 9), 2'b01, 15, 1'b0);
    endtask

    // lanes run in program order, so lane 1 sees lane 0's write
    task automatic model_bundle(input row_t r, input int row, output expect_t e,
                                output logic commits);
        isa_pkg::i_fmt_t f;
        isa_pkg::r_fmt_t g;
        logic [XLEN-1:0] imm_x;
        logic [XLEN-1:0] res;
        logic            taken;
        logic            redirect;
        e        = '0;
        e.row    = row;
        e.ftq    = r.ftq;
        commits  = 1'b0;
        redirect = 1'b0;
        for (int l = 0; l < backend_pkg::FETCH_WIDTH; l++) begin
            f     = r.inst[l].i;
            g     = r.inst[l].r;
            imm_x = {{(XLEN-16){f.imm[15]}}, f.imm};
            if (r.vld[l] && !redirect) begin
                case (f.opcode)
                    isa_pkg::OP_ADD, isa_pkg::OP_SUB, isa_pkg::OP_ADDI: begin
                        case (f.opcode)
                            isa_pkg::OP_ADD: res = model_rf[g.rs1] + model_rf[g.rs2];
                            isa_pkg::OP_SUB: res = model_rf[g.rs1] - model_rf[g.rs2];
                            default:         res = model_rf[f.rs1] + imm_x;
                        endcase
                        if (g.rd != 0) begin
                            model_rf[g.rd] = res;
                            e.wb_vld[l]    = 1'b1;
                            e.wb_rd[l]     = g.rd;
                            e.wb_data[l]   = res;
                            commits        = 1'b1;
                        end
                    end
                    isa_pkg::OP_BEQ, isa_pkg::OP_BNE: begin
                        taken   = (f.opcode == isa_pkg::OP_BEQ) ?
                                  (model_rf[f.rs1] == model_rf[f.rs2]) :
                                  (model_rf[f.rs1] != model_rf[f.rs2]);
                        commits = 1'b1;
                        // the entry reports its oldest branch only
                        if (!e.br_vld) begin
                            e.br_vld    = 1'b1;
                            e.br_taken  = taken;
                            e.br_target = ftq_start[r.ftq] + 4 * (l + imm_x);
                            redirect    = taken;
                        end
                    end
                    default: ;
                endcase
            end
        end
    endtask

    task automatic compare_word(string name, logic [XLEN-1:0] got, logic [XLEN-1:0] exp);
        if (got !== exp) begin
            err_cnt++;
            $display("error at %0t ns: %s got 0x%0h expected 0x%0h", $time, name, got, exp);
        end
    endtask

    task automatic check_flag(string name, logic got, logic exp);
        if (got !== exp) begin
            err_cnt++;
            $display("error at %0t ns: %s got %b expected %b", $time, name, got, exp);
        end
    endtask

    task automatic check_wb(int lane, backend_pkg::reg_idx_t rd, logic [XLEN-1:0] data);
        compare_word($sformatf("o_wb_rd[%0d]", lane), wb_rd[lane], rd);
        compare_word($sformatf("o_wb_data[%0d]", lane), wb_data[lane], data);
    endtask

    task automatic check_branch(backend_pkg::ftq_idx_t idx, logic taken, logic [XLEN-1:0] target);
        compare_word("o_branchwb_ftq_idx", br_ftq_idx, idx);
        check_flag("o_branchwb_taken", br_taken, taken);
        compare_word("o_branchwb_target", br_target, target);
        if (taken) begin
            compare_word("o_squash_pc", squash_pc, target);
        end
    endtask

    task automatic check_commit(backend_pkg::ftq_idx_t idx);
        compare_word("o_commit_ftq_idx", commit_ftq_idx, idx);
    endtask

    task automatic finish_row(int row, bit clean, string what);
        if (clean && !row_bad[row]) begin
            rows_ok++;
            $display("row %0d ftq %0d %s: ok", row, table_rows[row].ftq, what);
        end else begin
            rows_bad++;
            $display("row %0d ftq %0d %s: mismatch", row, table_rows[row].ftq, what);
        end
    endtask

    task automatic compare_outputs();
        expect_t e;
        int      errs;
        if (!commit_vld) begin
            for (int l = 0; l < backend_pkg::FETCH_WIDTH; l++) begin
                check_flag($sformatf("o_wb_vld[%0d]", l), wb_vld[l], 1'b0);
            end
            check_flag("o_branchwb_vld", br_vld, 1'b0);
            check_flag("o_squash_vld", squash_vld, 1'b0);
        end else if (exp_q.size() == 0) begin
            err_cnt++;
            $display("commit of ftq index %0d arrived with no bundle in flight", commit_ftq_idx);
        end else begin
            e    = exp_q.pop_front();
            errs = err_cnt;
            check_commit(e.ftq);
            for (int l = 0; l < backend_pkg::FETCH_WIDTH; l++) begin
                check_flag($sformatf("o_wb_vld[%0d]", l), wb_vld[l], e.wb_vld[l]);
                if (e.wb_vld[l]) begin
                    check_wb(l, e.wb_rd[l], e.wb_data[l]);
                end
            end
            check_flag("o_branchwb_vld", br_vld, e.br_vld);
            check_flag("o_squash_vld", squash_vld, e.br_vld && e.br_taken);
            if (e.br_vld) begin
                check_branch(e.ftq, e.br_taken, e.br_target);
            end
            finish_row(e.row, err_cnt == errs, "committed");
        end
    endtask

    // registered outputs are stable just after the edge
    always @(posedge clk) begin
        #1;
        if (rst_n) begin
            compare_outputs();
        end
    end

    initial begin
        int      cyc;
        int      errs;
        row_t    r;
        expect_t e;
        logic    commits;
        for (int l = 0; l < backend_pkg::FETCH_WIDTH; l++) begin
            inst_vld[l] = 1'b0;
            inst[l]     = '0;
        end
        ftq_idx = '0;
        void'($urandom(RAND_SEED));
        // word aligned start addresses
        for (int i = 0; i < 16; i++) begin
            ftq_start[i] = $urandom() & ~XLEN'(3);
        end
        for (int i = 0; i < backend_pkg::NUM_REGS; i++) begin
            model_rf[i] = '0;
        end
        fill_table();

        for (cyc = 0; cyc < WAIT_MAX && rst_n !== 1'b1; cyc++) begin
            @(posedge clk);
        end
        if (rst_n !== 1'b1) begin
            timed_out = 1'b1;
            $display("timeout: reset was never released");
        end else begin
            for (int j = 0; j < NUM_ROWS; j++) begin
                @(posedge clk);
                #DRIVE_DLY;
                r    = table_rows[j];
                errs = err_cnt;
                // o_stall now decides whether this bundle is dropped
                check_flag("o_stall", stall, r.exp_stall);
                row_bad[j] = (err_cnt != errs);
                for (int l = 0; l < backend_pkg::FETCH_WIDTH; l++) begin
                    inst_vld[l] = r.vld[l];
                    inst[l]     = r.inst[l];
                end
                ftq_idx = r.ftq;
                if (r.exp_stall) begin
                    finish_row(j, 1'b1, "dropped");
                end else begin
                    model_bundle(r, j, e, commits);
                    if (commits) begin
                        exp_q.push_back(e);
                    end else begin
                        finish_row(j, 1'b1, "no commit");
                    end
                end
            end
            @(posedge clk);
            #DRIVE_DLY;
            for (int l = 0; l < backend_pkg::FETCH_WIDTH; l++) begin
                inst_vld[l] = 1'b0;
            end
            for (cyc = 0; cyc < WAIT_MAX && exp_q.size() != 0; cyc++) begin
                @(posedge clk);
            end
            if (exp_q.size() != 0) begin
                timed_out = 1'b1;
                $display("timeout: %0d bundles never committed", exp_q.size());
            end
        end

        $display("rows %0d, ok %0d, bad %0d, errors %0d", NUM_ROWS, rows_ok, rows_bad, err_cnt);
        if (err_cnt == 0 && rows_bad == 0 && !timed_out) begin
            $display("sim passed");
        end else begin
            $display("sim failed");
        end
        $finish;
    end

endmodule

/* sim/tb_clock_gen.sv */
`timescale 1ns/1ns

module tb_clock_gen #(
    parameter int PERIOD     = 40,
    parameter int RST_CYCLES = 2
) (
    output logic o_clk,
    output logic o_rst_n
);

    initial begin
        o_clk = 1'b0;
        forever begin
            #(PERIOD / 2);
            o_clk = ~o_clk;
        end
    end

    // reset stays low across the first rising edges
    initial begin
        o_rst_n = 1'b0;
        repeat (RST_CYCLES) @(posedge o_clk);
        o_rst_n <= 1'b1;
    end

endmodule

/* design/mini_backend.sv */
`timescale 1ns/1ns

module mini_backend #(
    parameter int XLEN = 32
) (
    input  logic                  i_clk,
    input  logic                  i_rst_n,

    input  logic                  i_inst_vld [backend_pkg::FETCH_WIDTH],
    input  isa_pkg::inst_u        i_inst [backend_pkg::FETCH_WIDTH],
    input  backend_pkg::ftq_idx_t i_ftq_idx,
    output logic                  o_stall,

    // combinational start address lookup in the fetch queue
    output backend_pkg::ftq_idx_t o_read_ftq_idx,
    input  logic [XLEN-1:0]       i_read_ftq_start_addr,

    output logic                  o_wb_vld [backend_pkg::FETCH_WIDTH],
    output backend_pkg::reg_idx_t o_wb_rd [backend_pkg::FETCH_WIDTH],
    output logic [XLEN-1:0]       o_wb_data [backend_pkg::FETCH_WIDTH],

    output logic                  o_branchwb_vld,
    output backend_pkg::ftq_idx_t o_branchwb_ftq_idx,
    output logic                  o_branchwb_taken,
    output logic [XLEN-1:0]       o_branchwb_target,

    output logic                  o_squash_vld,
    output logic [XLEN-1:0]       o_squash_pc,

    output logic                  o_commit_vld,
    output backend_pkg::ftq_idx_t o_commit_ftq_idx
);

    backend_pkg::uop_t     dec_uop [backend_pkg::FETCH_WIDTH];
    backend_pkg::ftq_idx_t dec_ftq_idx;
    logic                  dec_vld;
    logic                  kill_younger;

    logic                  exe_res_vld [backend_pkg::FETCH_WIDTH];
    backend_pkg::reg_idx_t exe_res_rd [backend_pkg::FETCH_WIDTH];
    logic [XLEN-1:0]       exe_res_data [backend_pkg::FETCH_WIDTH];
    logic                  exe_br_vld [backend_pkg::FETCH_WIDTH];
    logic                  exe_br_taken [backend_pkg::FETCH_WIDTH];
    logic [XLEN-1:0]       exe_br_target [backend_pkg::FETCH_WIDTH];
    backend_pkg::ftq_idx_t exe_ftq_idx;

    // fetch holds off for the cycle after a taken branch resolves
    assign o_stall = kill_younger;

    decode_stage u_decode (
        .i_clk     ( i_clk        ),
        .i_rst_n   ( i_rst_n      ),
        .i_inst_vld( i_inst_vld   ),
        .i_inst    ( i_inst       ),
        .i_ftq_idx ( i_ftq_idx    ),
        .i_kill    ( kill_younger ),
        .o_uop     ( dec_uop      ),
        .o_ftq_idx ( dec_ftq_idx  ),
        .o_vld     ( dec_vld      )
    );

    execute_stage #(.XLEN(XLEN)) u_execute (
        .i_clk                ( i_clk                 ),
        .i_rst_n              ( i_rst_n               ),
        .i_uop                ( dec_uop               ),
        .i_ftq_idx            ( dec_ftq_idx           ),
        .i_vld                ( dec_vld               ),
        .i_read_ftq_start_addr( i_read_ftq_start_addr ),
        .o_read_ftq_idx       ( o_read_ftq_idx        ),
        .o_res_vld            ( exe_res_vld           ),
        .o_res_rd             ( exe_res_rd            ),
        .o_res_data           ( exe_res_data          ),
        .o_br_vld             ( exe_br_vld            ),
        .o_br_taken           ( exe_br_taken          ),
        .o_br_target          ( exe_br_target         ),
        .o_ftq_idx            ( exe_ftq_idx           ),
        .o_kill_younger       ( kill_younger          )
    );

    result_stage #(.XLEN(XLEN)) u_result (
        .i_clk             ( i_clk              ),
        .i_rst_n           ( i_rst_n            ),
        .i_res_vld         ( exe_res_vld        ),
        .i_res_rd          ( exe_res_rd         ),
        .i_res_data        ( exe_res_data       ),
        .i_br_vld          ( exe_br_vld         ),
        .i_br_taken        ( exe_br_taken       ),
        .i_br_target       ( exe_br_target      ),
        .i_ftq_idx         ( exe_ftq_idx        ),
        .o_wb_vld          ( o_wb_vld           ),
        .o_wb_rd           ( o_wb_rd            ),
        .o_wb_data         ( o_wb_data          ),
        .o_branchwb_vld    ( o_branchwb_vld     ),
        .o_branchwb_ftq_idx( o_branchwb_ftq_idx ),
        .o_branchwb_taken  ( o_branchwb_taken   ),
        .o_branchwb_target ( o_branchwb_target  ),
        .o_squash_vld      ( o_squash_vld       ),
        .o_squash_pc       ( o_squash_pc        ),
        .o_commit_vld      ( o_commit_vld       ),
        .o_commit_ftq_idx  ( o_commit_ftq_idx   )
    );

endmodule

/* design/result_stage.sv */
`timescale 1ns/1ns

module result_stage #(
    parameter int XLEN = 32
) (
    input  logic                  i_clk,
    input  logic                  i_rst_n,
    input  logic                  i_res_vld [backend_pkg::FETCH_WIDTH],
    input  backend_pkg::reg_idx_t i_res_rd [backend_pkg::FETCH_WIDTH],
    input  logic [XLEN-1:0]       i_res_data [backend_pkg::FETCH_WIDTH],
    input  logic                  i_br_vld [backend_pkg::FETCH_WIDTH],
    input  logic                  i_br_taken [backend_pkg::FETCH_WIDTH],
    input  logic [XLEN-1:0]       i_br_target [backend_pkg::FETCH_WIDTH],
    input  backend_pkg::ftq_idx_t i_ftq_idx,
    output logic                  o_wb_vld [backend_pkg::FETCH_WIDTH],
    output backend_pkg::reg_idx_t o_wb_rd [backend_pkg::FETCH_WIDTH],
    output logic [XLEN-1:0]       o_wb_data [backend_pkg::FETCH_WIDTH],
    output logic                  o_branchwb_vld,
    output backend_pkg::ftq_idx_t o_branchwb_ftq_idx,
    output logic                  o_branchwb_taken,
    output logic [XLEN-1:0]       o_branchwb_target,
    output logic                  o_squash_vld,
    output logic [XLEN-1:0]       o_squash_pc,
    output logic                  o_commit_vld,
    output backend_pkg::ftq_idx_t o_commit_ftq_idx
);

    logic            sel_vld;
    logic            sel_taken;
    logic [XLEN-1:0] sel_target;
    logic            any_lane;

    // scan from the youngest lane so the oldest branch is kept
    always_comb begin
        sel_vld    = 1'b0;
        sel_taken  = 1'b0;
        sel_target = '0;
        any_lane   = 1'b0;
        for (int l = backend_pkg::FETCH_WIDTH - 1; l >= 0; l--) begin
            if (i_br_vld[l]) begin
                sel_vld    = 1'b1;
                sel_taken  = i_br_taken[l];
                sel_target = i_br_target[l];
            end
            any_lane = any_lane | i_res_vld[l] | i_br_vld[l];
        end
    end

    always_ff @(posedge i_clk) begin
        if (!i_rst_n) begin
            o_branchwb_vld <= 1'b0;
            o_squash_vld   <= 1'b0;
            o_commit_vld   <= 1'b0;
        end else begin
            o_branchwb_vld <= sel_vld;
            o_squash_vld   <= sel_vld && sel_taken;
            o_commit_vld   <= any_lane;
        end
        o_branchwb_ftq_idx <= i_ftq_idx;
        o_branchwb_taken   <= sel_taken;
        o_branchwb_target  <= sel_target;
        o_commit_ftq_idx   <= i_ftq_idx;
    end

    // redirect goes to the resolved target of the selected branch
    assign o_squash_pc = o_branchwb_target;

    always_ff @(posedge i_clk) begin
        for (int l = 0; l < backend_pkg::FETCH_WIDTH; l++) begin
            if (!i_rst_n) begin
                o_wb_vld[l] <= 1'b0;
            end else begin
                o_wb_vld[l] <= i_res_vld[l];
            end
            o_wb_rd[l]   <= i_res_rd[l];
            o_wb_data[l] <= i_res_data[l];
        end
    end

    // nothing younger survives behind a taken lane 0 branch
    a_kill_behind_taken: assert property (@(posedge i_clk) disable iff (!i_rst_n)
        i_br_vld[0] && i_br_taken[0] |-> !i_res_vld[1] && !i_br_vld[1]);

endmodule

/* design/execute_stage.sv */
`timescale 1ns/1ns

module execute_stage #(
    parameter int XLEN = 32
) (
    input  logic                  i_clk,
    input  logic                  i_rst_n,
    input  backend_pkg::uop_t     i_uop [backend_pkg::FETCH_WIDTH],
    input  backend_pkg::ftq_idx_t i_ftq_idx,
    input  logic                  i_vld,
    input  logic [XLEN-1:0]       i_read_ftq_start_addr,
    output backend_pkg::ftq_idx_t o_read_ftq_idx,
    output logic                  o_res_vld [backend_pkg::FETCH_WIDTH],
    output backend_pkg::reg_idx_t o_res_rd [backend_pkg::FETCH_WIDTH],
    output logic [XLEN-1:0]       o_res_data [backend_pkg::FETCH_WIDTH],
    output logic                  o_br_vld [backend_pkg::FETCH_WIDTH],
    output logic                  o_br_taken [backend_pkg::FETCH_WIDTH],
    output logic [XLEN-1:0]       o_br_target [backend_pkg::FETCH_WIDTH],
    output backend_pkg::ftq_idx_t o_ftq_idx,
    output logic                  o_kill_younger
);

    logic [XLEN-1:0] rf [backend_pkg::NUM_REGS];

    logic [XLEN-1:0] src1 [backend_pkg::FETCH_WIDTH];
    logic [XLEN-1:0] src2 [backend_pkg::FETCH_WIDTH];
    logic [XLEN-1:0] alu_res [backend_pkg::FETCH_WIDTH];
    logic [XLEN-1:0] target [backend_pkg::FETCH_WIDTH];
    logic            taken [backend_pkg::FETCH_WIDTH];
    logic            alive [backend_pkg::FETCH_WIDTH];
    logic            wr [backend_pkg::FETCH_WIDTH];
    logic            br [backend_pkg::FETCH_WIDTH];
    logic            fwd_en;

    // the start address is read for the bundle held in decode
    assign o_read_ftq_idx = i_ftq_idx;

    assign fwd_en = alive[0] && (i_uop[0].kind == backend_pkg::UOP_ALU) && i_uop[0].we;

    for (genvar l = 0; l < backend_pkg::FETCH_WIDTH; l++) begin : g_lane
        logic [XLEN-1:0] imm_x;

        assign imm_x = XLEN'($signed(i_uop[l].imm));

        if (l == 0) begin : g_oldest
            assign src1[l]  = rf[i_uop[l].rs1];
            assign src2[l]  = rf[i_uop[l].rs2];
            assign alive[l] = i_vld && i_uop[l].valid;
        end else begin : g_younger
            // lane 0 result bypassed inside the bundle
            assign src1[l]  = (fwd_en && i_uop[l].rs1 == i_uop[0].rd) ? alu_res[0] :
                              rf[i_uop[l].rs1];
            assign src2[l]  = (fwd_en && i_uop[l].rs2 == i_uop[0].rd) ? alu_res[0] :
                              rf[i_uop[l].rs2];
            assign alive[l] = i_vld && i_uop[l].valid && !taken[0];
        end

        always_comb begin
            case (i_uop[l].alu_op)
                backend_pkg::ALU_SUB:  alu_res[l] = src1[l] - src2[l];
                backend_pkg::ALU_ADDI: alu_res[l] = src1[l] + imm_x;
                default:               alu_res[l] = src1[l] + src2[l];
            endcase
        end

        assign br[l]     = alive[l] && (i_uop[l].kind == backend_pkg::UOP_BRANCH);
        assign taken[l]  = br[l] && ((i_uop[l].br_sense == backend_pkg::BR_EQ) ?
                                     (src1[l] == src2[l]) : (src1[l] != src2[l]));
        assign wr[l]     = alive[l] && (i_uop[l].kind == backend_pkg::UOP_ALU) && i_uop[l].we;
        // slot offset is the lane number, both in words
        assign target[l] = i_read_ftq_start_addr + ((XLEN'(l) + imm_x) << 2);

        a_no_r0_write: assert property (@(posedge i_clk) disable iff (!i_rst_n)
            wr[l] |-> i_uop[l].rd != '0);
    end

    // only the oldest branch of the entry may redirect
    assign o_kill_younger = taken[0] || (taken[1] && !br[0]);

    always_ff @(posedge i_clk) begin
        if (!i_rst_n) begin
            for (int r = 0; r < backend_pkg::NUM_REGS; r++) begin
                rf[r] <= '0;
            end
        end else begin
            // younger lane wins on the same destination
            for (int l = 0; l < backend_pkg::FETCH_WIDTH; l++) begin
                if (wr[l]) begin
                    rf[i_uop[l].rd] <= alu_res[l];
                end
            end
        end
    end

    always_ff @(posedge i_clk) begin
        for (int l = 0; l < backend_pkg::FETCH_WIDTH; l++) begin
            if (!i_rst_n) begin
                o_res_vld[l] <= 1'b0;
                o_br_vld[l]  <= 1'b0;
            end else begin
                o_res_vld[l] <= wr[l];
                o_br_vld[l]  <= br[l];
            end
            o_res_rd[l]    <= i_uop[l].rd;
            o_res_data[l]  <= alu_res[l];
            o_br_taken[l]  <= taken[l];
            o_br_target[l] <= target[l];
        end
        o_ftq_idx <= i_ftq_idx;
    end

endmodule

/* design/decode_stage.sv */
`timescale 1ns/1ns

module decode_stage (
    input  logic                  i_clk,
    input  logic                  i_rst_n,
    input  logic                  i_inst_vld [backend_pkg::FETCH_WIDTH],
    input  isa_pkg::inst_u        i_inst [backend_pkg::FETCH_WIDTH],
    input  backend_pkg::ftq_idx_t i_ftq_idx,
    input  logic                  i_kill,
    output backend_pkg::uop_t     o_uop [backend_pkg::FETCH_WIDTH],
    output backend_pkg::ftq_idx_t o_ftq_idx,
    output logic                  o_vld
);

    isa_pkg::inst_u        inst_q [backend_pkg::FETCH_WIDTH];
    logic                  vld_q [backend_pkg::FETCH_WIDTH];
    backend_pkg::ftq_idx_t ftq_q;

    always_ff @(posedge i_clk) begin
        for (int l = 0; l < backend_pkg::FETCH_WIDTH; l++) begin
            if (!i_rst_n || i_kill) begin
                vld_q[l] <= 1'b0;
            end else begin
                vld_q[l] <= i_inst_vld[l];
            end
            inst_q[l] <= i_inst[l];
        end
        ftq_q <= i_ftq_idx;
    end

    always_comb begin
        o_vld = 1'b0;
        for (int l = 0; l < backend_pkg::FETCH_WIDTH; l++) begin
            o_vld = o_vld | vld_q[l];
        end
    end

    assign o_ftq_idx = ftq_q;

    for (genvar l = 0; l < backend_pkg::FETCH_WIDTH; l++) begin : g_lane
        always_comb begin
            o_uop[l] = '0;
            case (inst_q[l].r.opcode)
                isa_pkg::OP_ADD, isa_pkg::OP_SUB: begin
                    // a write to r0 has no effect, treat it like a nop
                    o_uop[l].valid  = vld_q[l] && (inst_q[l].r.rd != '0);
                    o_uop[l].kind   = backend_pkg::UOP_ALU;
                    o_uop[l].alu_op = (inst_q[l].r.opcode == isa_pkg::OP_ADD) ?
                                      backend_pkg::ALU_ADD : backend_pkg::ALU_SUB;
                    o_uop[l].rd     = inst_q[l].r.rd;
                    o_uop[l].rs1    = inst_q[l].r.rs1;
                    o_uop[l].rs2    = inst_q[l].r.rs2;
                    o_uop[l].we     = 1'b1;
                end
                isa_pkg::OP_ADDI: begin
                    o_uop[l].valid  = vld_q[l] && (inst_q[l].i.rd != '0);
                    o_uop[l].kind   = backend_pkg::UOP_ALU;
                    o_uop[l].alu_op = backend_pkg::ALU_ADDI;
                    o_uop[l].rd     = inst_q[l].i.rd;
                    o_uop[l].rs1    = inst_q[l].i.rs1;
                    o_uop[l].imm    = backend_pkg::IMM_W'($signed(inst_q[l].i.imm));
                    o_uop[l].we     = 1'b1;
                end
                isa_pkg::OP_BEQ, isa_pkg::OP_BNE: begin
                    o_uop[l].valid    = vld_q[l];
                    o_uop[l].kind     = backend_pkg::UOP_BRANCH;
                    o_uop[l].rs1      = inst_q[l].i.rs1;
                    o_uop[l].rs2      = inst_q[l].i.rs2;
                    o_uop[l].imm      = backend_pkg::IMM_W'($signed(inst_q[l].i.imm));
                    o_uop[l].br_sense = (inst_q[l].i.opcode == isa_pkg::OP_BEQ) ?
                                        backend_pkg::BR_EQ : backend_pkg::BR_NE;
                end
                default: begin
                    o_uop[l].valid = 1'b0;
                end
            endcase
        end

        // a lane captured as valid carries a defined opcode
        a_known_opcode: assert property (@(posedge i_clk) disable iff (!i_rst_n)
            vld_q[l] |-> inst_q[l].r.opcode inside {isa_pkg::OP_NOP, isa_pkg::OP_ADD,
                isa_pkg::OP_SUB, isa_pkg::OP_ADDI, isa_pkg::OP_BEQ, isa_pkg::OP_BNE});
    end

endmodule

/* design/backend_pkg.sv */
package backend_pkg;

    localparam int FETCH_WIDTH = 2;
    localparam int NUM_REGS    = 8;
    localparam int IMM_W       = 32;

    typedef logic [3:0] ftq_idx_t;
    typedef logic [2:0] reg_idx_t;

    typedef enum logic {
        UOP_ALU,
        UOP_BRANCH
    } uop_kind_e;

    typedef enum logic [1:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_ADDI
    } alu_op_e;

    typedef enum logic {
        BR_EQ,
        BR_NE
    } br_sense_e;

    typedef struct packed {
        logic             valid;
        uop_kind_e        kind;
        alu_op_e          alu_op;
        reg_idx_t         rd;
        reg_idx_t         rs1;
        reg_idx_t         rs2;
        logic [IMM_W-1:0] imm;
        logic             we;
        br_sense_e        br_sense;
    } uop_t;

endpackage

/* design/isa_pkg.sv */
package isa_pkg;

    typedef enum logic [3:0] {
        OP_NOP  = 4'd0,
        OP_ADD  = 4'd1,
        OP_SUB  = 4'd2,
        OP_ADDI = 4'd3,
        OP_BEQ  = 4'd4,
        OP_BNE  = 4'd5
    } opcode_e;

    // register view used by add and sub
    typedef struct packed {
        opcode_e     opcode;
        logic [2:0]  rd;
        logic [2:0]  rs1;
        logic [2:0]  rs2;
        logic [18:0] unused;
    } r_fmt_t;

    // immediate view used by addi and the compare branches
    // for branches the immediate is a word offset from the slot
    typedef struct packed {
        opcode_e     opcode;
        logic [2:0]  rd;
        logic [2:0]  rs1;
        logic [2:0]  rs2;
        logic [2:0]  pad;
        logic [15:0] imm;
    } i_fmt_t;

    typedef union packed {
        r_fmt_t r;
        i_fmt_t i;
    } inst_u;

endpackage
